// File: rvExec.f
logic/rvExecPkg.sv
logic/resultBus.sv
logic/alu.sv
logic/regFile.sv
logic/idExReg.sv
logic/exStage.sv
logic/retireStages.sv
logic/rvExecTop.sv
test/rvExec_assertions.sv
test/rvExecTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rvExecTb
FILELIST  ?= rvExec.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASSTEXT  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)

// File: test/rvExecTrace.txt
# test op srcA srcB imm pc rs1 rs2 rd we expMemResult expMemStoreData
# op and selects are mnemonics, register fields decimal, all other words hex
1 add   rs1 imm 12345678 00000000  0  0  1 1 12345678 00000000
1 add   rs1 imm f0000f00 00000000  0  0  2 1 f0000f00 00000000
1 sub   rs1 rs2 00000000 00000000  1  2  3 1 22344778 f0000f00
1 and   rs1 rs2 00000000 00000000  1  2  4 1 10000600 f0000f00
1 or    rs1 rs2 00000000 00000000  1  2  5 1 f2345f78 f0000f00
1 xor   rs1 rs2 00000000 00000000  1  2  6 1 e2345978 f0000f00
1 sll   rs1 imm 00000024 00000000  1  0  7 1 23456780 00000000
1 srl   rs1 imm 00000008 00000000  2  0  8 1 00f0000f 00000000
1 sra   rs1 imm 00000008 00000000  2  0  9 1 fff0000f 00000000
1 slt   rs1 rs2 00000000 00000000  2  1 10 1 00000001 12345678
1 sltu  rs1 rs2 00000000 00000000  2  1 11 1 00000000 12345678
1 passb rs1 imm abcde000 00000000  0  0 12 1 abcde000 00000000
2 add   rs1 imm 00000100 00000000  0  0 13 1 00000100 00000000
2 add   rs1 imm 00000023 00000000 13  0 14 1 00000123 00000000
3 add   rs1 imm 00000050 00000000  0  0 15 1 00000050 00000000
3 add   rs1 imm 00000011 00000000  0  0 18 1 00000011 00000000
3 add   rs1 imm 00000005 00000000 15  0 18 1 00000055 00000000
3 add   rs1 rs2 00000000 00000000 18 18 19 1 000000aa 00000055
4 add   rs1 imm 00000777 00000000  0  0 20 1 00000777 00000000
4 add   rs1 imm 00000001 00000000  0  0 21 1 00000001 00000000
4 add   rs1 imm 00000002 00000000  0  0 22 1 00000002 00000000
4 add   rs1 imm 00000001 00000000 20  0 23 1 00000778 00000000
5 add   rs1 imm 00000099 00000000  0  0  0 1 00000099 00000000
5 add   rs1 imm 00000005 00000000  0  0 24 1 00000005 00000000
5 add   rs1 rs2 00000000 00000000  0  0 25 1 00000000 00000000
5 or    rs1 rs2 00000000 00000000  0  0 26 1 00000000 00000000
6 add   pc  four 00000000 00001000 0  0 27 1 00001004 00000000
6 add   rs1 imm cafe0000 00000000  0  0 28 1 cafe0000 00000000
6 add   rs1 imm 00000008 00000000 27 28 29 1 0000100c cafe0000
6 add   pc  imm 00000010 00002000  0  0 30 1 00002010 00000000

// File: test/rvExecTb.sv
`timescale 1ns/1ps
`default_nettype none

module rvExecTb;
    import rvExecPkg::*;

    localparam int MaxLines = 64;
    localparam int MaxTests = 16;

    logic                clk = 1'b0;
    logic                rst;
    logic                issueValid;
    logic [3:0]          aluCode;
    logic                srcA;
    logic [1:0]          srcB;
    logic [Xlen-1:0]     imm;
    logic [Xlen-1:0]     pc;
    logic [RegAddrW-1:0] rs1Addr;
    logic [RegAddrW-1:0] rs2Addr;
    logic [RegAddrW-1:0] rdAddr;
    logic                regWrite;
    logic                memValid;
    logic [RegAddrW-1:0] memRdAddr;
    logic                memRegWrite;
    logic [Xlen-1:0]     memResult;
    logic [Xlen-1:0]     memStoreData;
    logic                wbValid;
    logic [RegAddrW-1:0] wbRdAddr;
    logic                wbRegWrite;
    logic [Xlen-1:0]     wbData;

    int                  traceTest [MaxLines];
    logic [3:0]          traceAlu [MaxLines];
    logic                traceSrcA [MaxLines];
    logic [1:0]          traceSrcB [MaxLines];
    logic [Xlen-1:0]     traceImm [MaxLines];
    logic [Xlen-1:0]     tracePc [MaxLines];
    logic [RegAddrW-1:0] traceRs1 [MaxLines];
    logic [RegAddrW-1:0] traceRs2 [MaxLines];
    logic [RegAddrW-1:0] traceRd [MaxLines];
    logic                traceWe [MaxLines];
    logic [Xlen-1:0]     traceRes [MaxLines];
    logic [Xlen-1:0]     traceStore [MaxLines];
    int                  bubbleBefore [MaxLines];
    int                  lineCount = 0;

    // expected MEM results in issue order
    int                  expTestQ [$];
    logic [Xlen-1:0]     expResQ [$];
    logic [Xlen-1:0]     expStoreQ [$];
    logic [RegAddrW-1:0] expRdQ [$];
    logic                expWeQ [$];

    int testExpected [MaxTests];
    int testChecked [MaxTests];
    int testErrors [MaxTests];
    int errorCount = 0;                       // result checks
    int setupErrors = 0;                      // trace problems
    int checkCount = 0;
    int limitCycles = 0;

    always #5 clk = ~clk;

    rvExecTop DUT (
        .clk          (clk),
        .rst          (rst),
        .issueValid   (issueValid),
        .aluCode      (aluCode),
        .srcA         (srcA),
        .srcB         (srcB),
        .imm          (imm),
        .pc           (pc),
        .rs1Addr      (rs1Addr),
        .rs2Addr      (rs2Addr),
        .rdAddr       (rdAddr),
        .regWrite     (regWrite),
        .memValid     (memValid),
        .memRdAddr    (memRdAddr),
        .memRegWrite  (memRegWrite),
        .memResult    (memResult),
        .memStoreData (memStoreData),
        .wbValid      (wbValid),
        .wbRdAddr     (wbRdAddr),
        .wbRegWrite   (wbRegWrite),
        .wbData       (wbData)
    );

    bind rvExecTop rvExec_assertions assertInst (
        .clk         (clk),
        .rst         (rst),
        .rs1Addr     (rs1Addr),
        .rs2Addr     (rs2Addr),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data),
        .memValid    (memValid),
        .memRegWrite (memRegWrite),
        .memRdAddr   (memRdAddr),
        .memResult   (memResult),
        .wbValid     (wbValid),
        .wbRegWrite  (wbRegWrite),
        .wbRdAddr    (wbRdAddr),
        .wbData      (wbData)
    );

    function automatic int aluFromName(input string name);
        case (name)
            "add":   return int'(AluAdd);
            "sub":   return int'(AluSub);
            "and":   return int'(AluAnd);
            "or":    return int'(AluOr);
            "xor":   return int'(AluXor);
            "sll":   return int'(AluSll);
            "srl":   return int'(AluSrl);
            "sra":   return int'(AluSra);
            "slt":   return int'(AluSlt);
            "sltu":  return int'(AluSltu);
            "passb": return int'(AluPassB);
            default: return -1;
        endcase
    endfunction

    function automatic int srcAFromName(input string name);
        case (name)
            "rs1":   return int'(SrcARs1);
            "pc":    return int'(SrcAPc);
            default: return -1;
        endcase
    endfunction

    function automatic int srcBFromName(input string name);
        case (name)
            "rs2":   return int'(SrcBRs2);
            "imm":   return int'(SrcBImm);
            "four":  return int'(SrcBFour);
            default: return -1;
        endcase
    endfunction

    task automatic loadTrace();
        int               fd;
        int               n;
        int               tNum;
        int               r1;
        int               r2;
        int               rd;
        int               we;
        int               aluV;
        int               aV;
        int               bV;
        string            opName;
        string            aName;
        string            bName;
        logic [31:0]      immV;
        logic [31:0]      pcV;
        logic [31:0]      resV;
        logic [31:0]      stV;
        logic [8*160-1:0] line;

        fd = $fopen("test/rvExecTrace.txt", "r");
        if (fd == 0) begin
            $display("could not open test/rvExecTrace.txt");
            setupErrors++;
            return;
        end
        while (!$feof(fd) && lineCount < MaxLines) begin
            line = '0;
            void'($fgets(line, fd));
            n = $sscanf(line, "%d %s %s %s %h %h %d %d %d %d %h %h", tNum, opName, aName,
                        bName, immV, pcV, r1, r2, rd, we, resV, stV);
            if (n == 12) begin
                aluV = aluFromName(opName);
                aV   = srcAFromName(aName);
                bV   = srcBFromName(bName);
                if (aluV < 0 || aV < 0 || bV < 0 || tNum < 1 || tNum >= MaxTests) begin
                    $display("unknown field in trace line of test %0d", tNum);
                    setupErrors++;
                end else begin
                    traceTest[lineCount]  = tNum;
                    traceAlu[lineCount]   = aluV[3:0];
                    traceSrcA[lineCount]  = aV[0];
                    traceSrcB[lineCount]  = bV[1:0];
                    traceImm[lineCount]   = immV;
                    tracePc[lineCount]    = pcV;
                    traceRs1[lineCount]   = r1[RegAddrW-1:0];
                    traceRs2[lineCount]   = r2[RegAddrW-1:0];
                    traceRd[lineCount]    = rd[RegAddrW-1:0];
                    traceWe[lineCount]    = we[0];
                    traceRes[lineCount]   = resV;
                    traceStore[lineCount] = stV;
                    testExpected[tNum]++;
                    lineCount++;
                end
            end else if (n > 0) begin
                $display("trace line with only %0d of 12 fields skipped", n);
                setupErrors++;
            end
        end
        $fclose(fd);
        if (lineCount == 0) begin
            $display("trace file holds no instructions");
            setupErrors++;
        end
    endtask

    task automatic driveIdle();
        issueValid = 1'b0;
        aluCode    = '0;
        srcA       = 1'b0;
        srcB       = '0;
        imm        = '0;
        pc         = '0;
        rs1Addr    = '0;
        rs2Addr    = '0;
        rdAddr     = '0;
        regWrite   = 1'b0;
    endtask

    // random fields, regWrite may be high but must be ignored
    task automatic driveBubble();
        logic [31:0] r;

        r = $urandom;
        issueValid = 1'b0;
        regWrite   = r[0];
        rdAddr     = r[5:1];
        rs1Addr    = r[10:6];
        rs2Addr    = r[15:11];
        aluCode    = r[19:16];
        srcA       = r[20];
        srcB       = r[22:21];
        imm        = $urandom;
        pc         = $urandom;
    endtask

    task automatic issueLine(input int i);
        issueValid = 1'b1;
        aluCode    = traceAlu[i];
        srcA       = traceSrcA[i];
        srcB       = traceSrcB[i];
        imm        = traceImm[i];
        pc         = tracePc[i];
        rs1Addr    = traceRs1[i];
        rs2Addr    = traceRs2[i];
        rdAddr     = traceRd[i];
        regWrite   = traceWe[i];
        expTestQ.push_back(traceTest[i]);
        expResQ.push_back(traceRes[i]);
        expStoreQ.push_back(traceStore[i]);
        expRdQ.push_back(traceRd[i]);
        expWeQ.push_back(traceWe[i]);
    endtask

    task automatic checkResult();
        int                  t;
        int                  errs;
        logic [Xlen-1:0]     eRes;
        logic [Xlen-1:0]     eStore;
        logic [RegAddrW-1:0] eRd;
        logic                eWe;

        t      = expTestQ.pop_front();
        eRes   = expResQ.pop_front();
        eStore = expStoreQ.pop_front();
        eRd    = expRdQ.pop_front();
        eWe    = expWeQ.pop_front();
        errs   = 0;
        if (memResult !== eRes) begin
            $display("MISMATCH test %0d memResult expected %h got %h", t, eRes, memResult);
            errs++;
        end
        if (memStoreData !== eStore) begin
            $display("MISMATCH test %0d memStoreData expected %h got %h", t, eStore,
                     memStoreData);
            errs++;
        end
        if (memRdAddr !== eRd) begin
            $display("MISMATCH test %0d memRdAddr expected %h got %h", t, eRd, memRdAddr);
            errs++;
        end
        if (memRegWrite !== eWe) begin
            $display("MISMATCH test %0d memRegWrite expected %h got %h", t, eWe, memRegWrite);
            errs++;
        end
        checkCount++;
        errorCount += errs;
        testErrors[t] += errs;
        testChecked[t]++;
        if (testChecked[t] == testExpected[t]) begin
            if (testErrors[t] == 0) begin
                $display("test %0d ok, %0d results", t, testChecked[t]);
            end else begin
                $display("test %0d failed with %0d errors", t, testErrors[t]);
            end
        end
    endtask

    // MEM outputs sampled before this edge updates them
    always @(posedge clk) begin
        if (memValid === 1'b1) begin
            if (expTestQ.size() == 0) begin
                $display("result %h arrived with no instruction outstanding", memResult);
                errorCount++;
            end else begin
                checkResult();
            end
        end else if (rst === 1'b0 && memRegWrite !== 1'b0) begin
            // a bubble must not carry a write
            $display("MISMATCH memRegWrite expected %h got %h while memValid low", 1'b0,
                     memRegWrite);
            errorCount++;
        end
    end

    initial begin
        wait (limitCycles > 0);
        repeat (limitCycles) @(posedge clk);
        $display("timeout after %0d cycles with %0d results outstanding", limitCycles,
                 expTestQ.size());
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int          totalBubbles;
        int          testCount;

        rst = 1'b1;
        driveIdle();
        void'($urandom(32'h947d));
        loadTrace();
        totalBubbles = 0;
        for (int i = 0; i < lineCount; i++) begin
            bubbleBefore[i] = 0;
            if (i > 0 && traceTest[i] != traceTest[i-1]) begin
                bubbleBefore[i] = $urandom % 4;   // idle gap between tests
            end
            totalBubbles += bubbleBefore[i];
        end
        limitCycles = lineCount + totalBubbles + 20;

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < lineCount; i++) begin
            repeat (bubbleBefore[i]) begin
                driveBubble();
                @(posedge clk);
                #1;
            end
            issueLine(i);
            @(posedge clk);
            #1;
        end
        driveIdle();
        while (expTestQ.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);                // catch stray results

        testCount = 0;
        for (int t = 0; t < MaxTests; t++) begin
            if (testExpected[t] > 0) begin
                testCount++;
            end
        end
        $display("summary: %0d tests, %0d results checked, %0d errors, %0d trace errors",
                 testCount, checkCount, errorCount, setupErrors);
        if (errorCount == 0 && setupErrors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/rvExec_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rvExec_assertions (
    input logic                           clk,
    input logic                           rst,
    input logic [rvExecPkg::RegAddrW-1:0] rs1Addr,
    input logic [rvExecPkg::RegAddrW-1:0] rs2Addr,
    input logic [rvExecPkg::Xlen-1:0]     rs1Data,
    input logic [rvExecPkg::Xlen-1:0]     rs2Data,
    input logic                           memValid,
    input logic                           memRegWrite,
    input logic [rvExecPkg::RegAddrW-1:0] memRdAddr,
    input logic [rvExecPkg::Xlen-1:0]     memResult,
    input logic                           wbValid,
    input logic                           wbRegWrite,
    input logic [rvExecPkg::RegAddrW-1:0] wbRdAddr,
    input logic [rvExecPkg::Xlen-1:0]     wbData
);

    // both result stages empty after a reset edge
    resetEmpty: assert property (@(posedge clk) rst |=> (!memValid && !wbValid))
        else $error("memValid or wbValid high in the cycle after reset");

    wbFollowsMemCtrl: assert property (@(posedge clk) disable iff (rst)
        !rst |=> (wbValid == $past(memValid)) && (wbRegWrite == $past(memRegWrite)))
        else $error("wbBus control differs from previous memBus");

    wbFollowsMemData: assert property (@(posedge clk) disable iff (rst)
        memValid |=> (wbRdAddr == $past(memRdAddr)) && (wbData == $past(memResult)))
        else $error("wbBus data differs from previous memBus");

    // x0 reads zero, also while wb targets x0
    zeroRegister: assert property (@(posedge clk)
        ((rs1Addr != '0) || (rs1Data == '0)) && ((rs2Addr != '0) || (rs2Data == '0)))
        else $error("x0 read returned a nonzero value");

endmodule

`default_nettype wire

// File: logic/rvExecTop.sv
`timescale 1ns/1ps
`default_nettype none

module rvExecTop (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              issueValid,
    input  logic [3:0]                        aluCode,
    input  logic                              srcA,
    input  logic [1:0]                        srcB,
    input  logic [rvExecPkg::Xlen-1:0]        imm,
    input  logic [rvExecPkg::Xlen-1:0]        pc,
    input  logic [rvExecPkg::RegAddrW-1:0]    rs1Addr,
    input  logic [rvExecPkg::RegAddrW-1:0]    rs2Addr,
    input  logic [rvExecPkg::RegAddrW-1:0]    rdAddr,
    input  logic                              regWrite,
    output logic                              memValid,
    output logic [rvExecPkg::RegAddrW-1:0]    memRdAddr,
    output logic                              memRegWrite,
    output logic [rvExecPkg::Xlen-1:0]        memResult,
    output logic [rvExecPkg::Xlen-1:0]        memStoreData,
    output logic                              wbValid,
    output logic [rvExecPkg::RegAddrW-1:0]    wbRdAddr,
    output logic                              wbRegWrite,
    output logic [rvExecPkg::Xlen-1:0]        wbData
);
    import rvExecPkg::*;

    logic [Xlen-1:0]     rs1Data;
    logic [Xlen-1:0]     rs2Data;
    logic                validEx;
    logic [3:0]          aluCodeEx;
    logic                srcAEx;
    logic [1:0]          srcBEx;
    logic [Xlen-1:0]     immEx;
    logic [Xlen-1:0]     pcEx;
    logic [RegAddrW-1:0] rs1AddrEx;
    logic [RegAddrW-1:0] rs2AddrEx;
    logic [RegAddrW-1:0] rdAddrEx;
    logic                regWriteEx;
    logic [Xlen-1:0]     rs1DataEx;
    logic [Xlen-1:0]     rs2DataEx;
    logic [Xlen-1:0]     aluResult;
    logic [Xlen-1:0]     storeData;

    resultBus memBus ();                     // EX/MEM
    resultBus wbBus ();                      // MEM/WB

    regFile regFileInst (
        .clk     (clk),
        .rst     (rst),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .wb      (wbBus.consumer),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    idExReg idExInst (
        .clk        (clk),
        .rst        (rst),
        .valid      (issueValid),
        .aluCode    (aluCode),
        .srcA       (srcA),
        .srcB       (srcB),
        .imm        (imm),
        .pc         (pc),
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .rdAddr     (rdAddr),
        .regWrite   (regWrite),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .validEx    (validEx),
        .aluCodeEx  (aluCodeEx),
        .srcAEx     (srcAEx),
        .srcBEx     (srcBEx),
        .immEx      (immEx),
        .pcEx       (pcEx),
        .rs1AddrEx  (rs1AddrEx),
        .rs2AddrEx  (rs2AddrEx),
        .rdAddrEx   (rdAddrEx),
        .regWriteEx (regWriteEx),
        .rs1DataEx  (rs1DataEx),
        .rs2DataEx  (rs2DataEx)
    );

    exStage exInst (
        .aluCodeEx (aluCodeEx),
        .srcAEx    (srcAEx),
        .srcBEx    (srcBEx),
        .immEx     (immEx),
        .pcEx      (pcEx),
        .rs1AddrEx (rs1AddrEx),
        .rs2AddrEx (rs2AddrEx),
        .rs1DataEx (rs1DataEx),
        .rs2DataEx (rs2DataEx),
        .mem       (memBus.consumer),
        .wb        (wbBus.consumer),
        .aluResult (aluResult),
        .storeData (storeData)
    );

    retireStages retireInst (
        .clk          (clk),
        .rst          (rst),
        .validEx      (validEx),
        .regWriteEx   (regWriteEx),
        .rdAddrEx     (rdAddrEx),
        .aluResult    (aluResult),
        .storeData    (storeData),
        .mem          (memBus.producer),
        .wb           (wbBus.producer),
        .memStoreData (memStoreData)
    );

    // internal buses out as plain ports
    assign memValid    = memBus.valid;
    assign memRdAddr   = memBus.rdAddr;
    assign memRegWrite = memBus.regWrite;
    assign memResult   = memBus.result;
    assign wbValid     = wbBus.valid;
    assign wbRdAddr    = wbBus.rdAddr;
    assign wbRegWrite  = wbBus.regWrite;
    assign wbData      = wbBus.result;

endmodule

`default_nettype wire

// File: logic/retireStages.sv
`timescale 1ns/1ps
`default_nettype none

module retireStages (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              validEx,
    input  logic                              regWriteEx,
    input  logic [rvExecPkg::RegAddrW-1:0]    rdAddrEx,
    input  logic [rvExecPkg::Xlen-1:0]        aluResult,
    input  logic [rvExecPkg::Xlen-1:0]        storeData,
    resultBus.producer                        mem,
    resultBus.producer                        wb,
    output logic [rvExecPkg::Xlen-1:0]        memStoreData
);

    // EX/MEM and MEM/WB, one edge each
    always_ff @(posedge clk) begin
        if (rst) begin
            mem.valid    <= 1'b0;
            mem.regWrite <= 1'b0;
            wb.valid     <= 1'b0;
            wb.regWrite  <= 1'b0;
        end else begin
            mem.valid    <= validEx;
            mem.regWrite <= regWriteEx;
            wb.valid     <= mem.valid;
            wb.regWrite  <= mem.regWrite;
        end
        mem.rdAddr   <= rdAddrEx;
        mem.result   <= aluResult;
        memStoreData <= storeData;           // no data memory, exposed only
        wb.rdAddr    <= mem.rdAddr;
        wb.result    <= mem.result;
    end

endmodule

`default_nettype wire

// File: logic/exStage.sv
`timescale 1ns/1ps
`default_nettype none

module exStage (
    input  logic [3:0]                        aluCodeEx,
    input  logic                              srcAEx,
    input  logic [1:0]                        srcBEx,
    input  logic [rvExecPkg::Xlen-1:0]        immEx,
    input  logic [rvExecPkg::Xlen-1:0]        pcEx,
    input  logic [rvExecPkg::RegAddrW-1:0]    rs1AddrEx,
    input  logic [rvExecPkg::RegAddrW-1:0]    rs2AddrEx,
    input  logic [rvExecPkg::Xlen-1:0]        rs1DataEx,
    input  logic [rvExecPkg::Xlen-1:0]        rs2DataEx,
    resultBus.consumer                        mem,
    resultBus.consumer                        wb,
    output logic [rvExecPkg::Xlen-1:0]        aluResult,
    output logic [rvExecPkg::Xlen-1:0]        storeData
);
    import rvExecPkg::*;

    logic [1:0]      fwdA;
    logic [1:0]      fwdB;
    logic [Xlen-1:0] rs1Fwd;
    logic [Xlen-1:0] rs2Fwd;
    logic [Xlen-1:0] opA;
    logic [Xlen-1:0] opB;

    // MEM is newer than WB so it is tested first
    function automatic logic [1:0] fwdSel(input logic [RegAddrW-1:0] src);
        if (mem.regWrite && (mem.rdAddr != '0) && (mem.rdAddr == src)) begin
            return FwdMem;
        end else if (wb.regWrite && (wb.rdAddr != '0) && (wb.rdAddr == src)) begin
            return FwdWb;
        end
        return FwdNone;
    endfunction

    function automatic logic [Xlen-1:0] fwdMux(input logic [1:0]      sel,
                                               input logic [Xlen-1:0] rfData);
        case (sel)
            FwdMem:  return mem.result;
            FwdWb:   return wb.result;
            default: return rfData;
        endcase
    endfunction

    always_comb begin
        fwdA   = fwdSel(rs1AddrEx);
        fwdB   = fwdSel(rs2AddrEx);
        rs1Fwd = fwdMux(fwdA, rs1DataEx);
        rs2Fwd = fwdMux(fwdB, rs2DataEx);
    end

    assign opA = (srcAEx == SrcAPc) ? pcEx : rs1Fwd;

    always_comb begin
        case (srcBEx)
            SrcBImm:  opB = immEx;
            SrcBFour: opB = 32'd4;               // jal/jalr link
            default:  opB = rs2Fwd;
        endcase
    end

    assign storeData = rs2Fwd;                   // store sees forwarded rs2

    alu aluInst (
        .aluCode (aluCodeEx),
        .a       (opA),
        .b       (opB),
        .result  (aluResult)
    );

endmodule

`default_nettype wire

// File: logic/idExReg.sv
`timescale 1ns/1ps
`default_nettype none

module idExReg (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              valid,
    input  logic [3:0]                        aluCode,
    input  logic                              srcA,
    input  logic [1:0]                        srcB,
    input  logic [rvExecPkg::Xlen-1:0]        imm,
    input  logic [rvExecPkg::Xlen-1:0]        pc,
    input  logic [rvExecPkg::RegAddrW-1:0]    rs1Addr,
    input  logic [rvExecPkg::RegAddrW-1:0]    rs2Addr,
    input  logic [rvExecPkg::RegAddrW-1:0]    rdAddr,
    input  logic                              regWrite,
    input  logic [rvExecPkg::Xlen-1:0]        rs1Data,
    input  logic [rvExecPkg::Xlen-1:0]        rs2Data,
    output logic                              validEx,
    output logic [3:0]                        aluCodeEx,
    output logic                              srcAEx,
    output logic [1:0]                        srcBEx,
    output logic [rvExecPkg::Xlen-1:0]        immEx,
    output logic [rvExecPkg::Xlen-1:0]        pcEx,
    output logic [rvExecPkg::RegAddrW-1:0]    rs1AddrEx,
    output logic [rvExecPkg::RegAddrW-1:0]    rs2AddrEx,
    output logic [rvExecPkg::RegAddrW-1:0]    rdAddrEx,
    output logic                              regWriteEx,
    output logic [rvExecPkg::Xlen-1:0]        rs1DataEx,
    output logic [rvExecPkg::Xlen-1:0]        rs2DataEx
);

    always_ff @(posedge clk) begin
        if (rst) begin
            validEx    <= 1'b0;
            regWriteEx <= 1'b0;
        end else begin
            validEx    <= valid;
            regWriteEx <= valid & regWrite;  // bubble never writes
        end
        aluCodeEx <= aluCode;
        srcAEx    <= srcA;
        srcBEx    <= srcB;
        immEx     <= imm;
        pcEx      <= pc;
        rs1AddrEx <= rs1Addr;
        rs2AddrEx <= rs2Addr;
        rdAddrEx  <= rdAddr;
        rs1DataEx <= rs1Data;
        rs2DataEx <= rs2Data;
    end

endmodule

`default_nettype wire

// File: logic/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [rvExecPkg::RegAddrW-1:0]    rs1Addr,
    input  logic [rvExecPkg::RegAddrW-1:0]    rs2Addr,
    resultBus.consumer                        wb,
    output logic [rvExecPkg::Xlen-1:0]        rs1Data,
    output logic [rvExecPkg::Xlen-1:0]        rs2Data
);
    import rvExecPkg::*;

    logic [Xlen-1:0] regs [1:31];   // x0 has no storage
    logic            wrEn;

    assign wrEn = wb.regWrite && (wb.rdAddr != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wb.rdAddr] <= wb.result;
        end
    end

    // write data bypasses the array when the same register is written
    function automatic logic [Xlen-1:0] readPort(input logic [RegAddrW-1:0] addr);
        if (addr == '0) begin
            return '0;                           // x0 hardwired
        end else if (wrEn && (addr == wb.rdAddr)) begin
            return wb.result;                    // write-through
        end
        return regs[addr];
    endfunction

    always_comb rs1Data = readPort(rs1Addr);
    always_comb rs2Data = readPort(rs2Addr);

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [3:0]                     aluCode,
    input  logic [rvExecPkg::Xlen-1:0]     a,
    input  logic [rvExecPkg::Xlen-1:0]     b,
    output logic [rvExecPkg::Xlen-1:0]     result
);
    import rvExecPkg::*;

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = b[4:0];                  // only low five bits shift
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (aluCode)
            AluAdd:   result = a + b;
            AluSub:   result = a - b;
            AluAnd:   result = a & b;
            AluOr:    result = a | b;
            AluXor:   result = a ^ b;
            AluSll:   result = a << shamt;
            AluSrl:   result = a >> shamt;
            AluSra:   result = $unsigned($signed(a) >>> shamt);   // sign fill
            AluSlt:   result = {{(Xlen-1){1'b0}}, ltSigned};
            AluSltu:  result = {{(Xlen-1){1'b0}}, ltUnsigned};
            AluPassB: result = b;
            default:  result = a + b;            // unused codes behave as add
        endcase
    end

    // Shift amounts above 31 cannot occur since shamt is five bits wide,
    // so the shifts above match the RV32I definition without masking.

endmodule

`default_nettype wire

// File: logic/resultBus.sv
`timescale 1ns/1ps
`default_nettype none

// one pipeline stage's result as seen by later consumers
interface resultBus;
    import rvExecPkg::*;

    logic                valid;      // stage holds an instruction
    logic                regWrite;   // low for bubbles
    logic [RegAddrW-1:0] rdAddr;
    logic [Xlen-1:0]     result;

    modport producer (
        output valid,
        output regWrite,
        output rdAddr,
        output result
    );

    modport consumer (
        input valid,
        input regWrite,
        input rdAddr,
        input result
    );

endinterface

`default_nettype wire

// File: logic/rvExecPkg.sv
`default_nettype none

package rvExecPkg;

    localparam int Xlen     = 32;                 // RV32I data word
    localparam int RegAddrW = 5;                  // x0..x31

    // ALU operation codes
    localparam logic [3:0] AluAdd   = 4'b0000;
    localparam logic [3:0] AluSub   = 4'b0001;
    localparam logic [3:0] AluPassB = 4'b0010;    // lui style, result is b
    localparam logic [3:0] AluAnd   = 4'b0011;
    localparam logic [3:0] AluXor   = 4'b0100;
    localparam logic [3:0] AluOr    = 4'b0101;
    localparam logic [3:0] AluSll   = 4'b0110;
    localparam logic [3:0] AluSrl   = 4'b0111;
    localparam logic [3:0] AluSra   = 4'b1000;
    localparam logic [3:0] AluSlt   = 4'b1001;
    localparam logic [3:0] AluSltu  = 4'b1010;

    // operand A source
    localparam logic SrcARs1 = 1'b0;
    localparam logic SrcAPc  = 1'b1;

    // operand B source
    localparam logic [1:0] SrcBRs2  = 2'd0;
    localparam logic [1:0] SrcBImm  = 2'd1;
    localparam logic [1:0] SrcBFour = 2'd2;       // link address offset

    // forwarding mux select
    localparam logic [1:0] FwdNone = 2'd0;
    localparam logic [1:0] FwdWb   = 2'd1;
    localparam logic [1:0] FwdMem  = 2'd2;

endpackage

`default_nettype wire
